/* design/matmul_params.svh */
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// operand lane width in bits
`define MM_LANE_W 16

// matrix dimension, also the systolic tile size
`define MM_SIZE 4

// operand memory address width, one word per k index
`define MM_ADDR_W 2

// run count at which done rises, covers skew fill and grid drain
`define MM_DONE_COUNT (3 * `MM_SIZE + 2)

// output select width, 16 results
`define MM_SEL_W 4

`endif

/* design/matmul_pkg.sv */
`include "matmul_params.svh"

package matmul_pkg;

  // one operand
  typedef logic [`MM_LANE_W-1:0] lane_t;

  // one memory word, also one skewed operand stream
  typedef lane_t [`MM_SIZE-1:0] row_t;

  // accumulator, wraps modulo 2**32
  typedef logic [2*`MM_LANE_W-1:0] acc_t;

  // all results, entry index is row * size + column
  typedef acc_t [`MM_SIZE*`MM_SIZE-1:0] tile_t;

  // load port
  // we_a and we_b pick which operand memory takes the word
  typedef struct packed {
    logic [`MM_ADDR_W-1:0] addr;
    row_t                  data;
    logic                  we_a;
    logic                  we_b;
  } load_req_t;

endpackage

/* design/operand_feeder.sv */
`include "matmul_params.svh"

module operand_feeder (
  input  logic                   clk,
  input  logic                   reset,
  input  matmul_pkg::load_req_t  load,
  input  logic                   load_en,
  input  logic                   write_en,
  input  logic                   window,
  input  logic [`MM_ADDR_W-1:0]  rd_addr,
  output matmul_pkg::row_t       stream
);

  import matmul_pkg::*;

  row_t                  mem [`MM_SIZE];
  logic [`MM_ADDR_W-1:0] addr;
  row_t                  rd_row;
  logic                  window_q;
  row_t                  row_gated;

  // load port owns the address while loading
  assign addr = load_en ? load.addr : rd_addr;

  always_ff @(posedge clk) begin
    if (load_en && write_en) begin
      mem[addr] <= load.data;
    end
    rd_row <= mem[addr];
  end

  // window flag aligned with the registered read
  always_ff @(posedge clk) begin
    if (reset) begin
      window_q <= 1'b0;
    end else begin
      window_q <= window;
    end
  end

  // outside the read window the lanes carry zeros
  assign row_gated = window_q ? rd_row : '0;

  // diagonal skew, lane i goes through i registers
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign stream[i] = row_gated[i];
    end else begin : g_delay
      lane_t [i-1:0] pipe;

      always_ff @(posedge clk) begin
        if (reset) begin
          pipe <= '0;
        end else begin
          pipe[0] <= row_gated[i];
          for (int s = 1; s < i; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign stream[i] = pipe[i-1];
    end
  end

  // loading while a run reads the memory would corrupt the stream
  a_no_write_in_window : assert property (
    @(posedge clk) disable iff (reset)
    !(write_en && window)
  ) else $error("operand write during read window");

endmodule

/* design/processing_element.sv */
module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::lane_t a_in,
  input  matmul_pkg::lane_t b_in,
  output matmul_pkg::lane_t a_out,
  output matmul_pkg::lane_t b_out,
  output matmul_pkg::acc_t  acc
);

  import matmul_pkg::*;

  acc_t product;

  // full 32-bit product of two 16-bit lanes
  assign product = acc_t'(a_in) * acc_t'(b_in);

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      a_out <= '0;
      b_out <= '0;
      acc   <= '0;
    end else begin
      // a moves east, b moves south
      a_out <= a_in;
      b_out <= b_in;
      acc   <= acc + product;
    end
  end

endmodule

/* design/systolic_array.sv */
`include "matmul_params.svh"

module systolic_array (
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  matmul_pkg::row_t  a_rows,
  input  matmul_pkg::row_t  b_cols,
  output matmul_pkg::tile_t tile
);

  import matmul_pkg::*;

  logic clear;

  // operand registers of each cell, [row][column]
  lane_t [`MM_SIZE-1:0][`MM_SIZE-1:0] a_east;
  lane_t [`MM_SIZE-1:0][`MM_SIZE-1:0] b_south;

  // accumulators hold zero between runs
  assign clear = !run;

  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MM_SIZE; j++) begin : g_col
      lane_t a_in;
      lane_t b_in;

      // west edge takes the skewed A lane
      if (j == 0) begin : g_a_edge
        assign a_in = a_rows[i];
      end else begin : g_a_link
        assign a_in = a_east[i][j-1];
      end

      // north edge takes the skewed B lane
      if (i == 0) begin : g_b_edge
        assign b_in = b_cols[j];
      end else begin : g_b_link
        assign b_in = b_south[i-1][j];
      end

      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .a_in  (a_in),
        .b_in  (b_in),
        .a_out (a_east[i][j]),
        .b_out (b_south[i][j]),
        .acc   (tile[i*`MM_SIZE+j])
      );
    end
  end

  // one edge with run low empties the whole grid
  a_clear_flushes_grid : assert property (
    @(posedge clk) disable iff (reset)
    !run |=> (tile == '0) && (a_east == '0) && (b_south == '0)
  ) else $error("grid not cleared after run dropped");

endmodule

/* design/matmul_top.sv */
`include "matmul_params.svh"

module matmul_top (
  input  logic                  clk,
  input  logic                  reset,
  input  matmul_pkg::load_req_t load,
  input  logic                  enable_writing_to_mem,
  input  logic                  start_mat_mul,
  input  logic [`MM_SEL_W-1:0]  out_sel,
  output matmul_pkg::acc_t      data_out,
  output logic                  done_mat_mul
);

  import matmul_pkg::*;

  localparam int RUN_W = $clog2(`MM_DONE_COUNT + 1);

  logic [RUN_W-1:0]      run_count;
  logic                  window;
  logic [`MM_ADDR_W-1:0] rd_addr;
  row_t                  a_stream;
  row_t                  b_stream;
  tile_t                 tile;

  // counts run cycles, parks at the done count
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      run_count <= '0;
    end else if (run_count != RUN_W'(`MM_DONE_COUNT)) begin
      run_count <= run_count + 1'b1;
    end
  end

  // level done, held until start drops
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      done_mat_mul <= 1'b0;
    end else if (run_count == RUN_W'(`MM_DONE_COUNT)) begin
      done_mat_mul <= 1'b1;
    end
  end

  // first size cycles of a run read the memories
  assign window  = start_mat_mul && (run_count < RUN_W'(`MM_SIZE));
  assign rd_addr = run_count[`MM_ADDR_W-1:0];

  operand_feeder u_feed_a (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .load_en  (enable_writing_to_mem),
    .write_en (load.we_a),
    .window   (window),
    .rd_addr  (rd_addr),
    .stream   (a_stream)
  );

  operand_feeder u_feed_b (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .load_en  (enable_writing_to_mem),
    .write_en (load.we_b),
    .window   (window),
    .rd_addr  (rd_addr),
    .stream   (b_stream)
  );

  systolic_array u_array (
    .clk    (clk),
    .reset  (reset),
    .run    (start_mat_mul),
    .a_rows (a_stream),
    .b_cols (b_stream),
    .tile   (tile)
  );

  // registered result select, only while done
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (done_mat_mul) begin
      data_out <= tile[out_sel];
    end
  end

  // start is still held when done first shows up
  a_done_needs_start : assert property (
    @(posedge clk) disable iff (reset)
    $rose(done_mat_mul) |-> start_mat_mul
  ) else $error("start dropped before done was seen");

endmodule

/* sim/tb_matmul_checks.sv */
`include "matmul_params.svh"

module matmul_checks (
  input logic                  clk,
  input logic                  reset,
  input matmul_pkg::load_req_t load,
  input logic                  enable_writing_to_mem,
  input logic                  start_mat_mul,
  input logic [`MM_SEL_W-1:0]  out_sel,
  input matmul_pkg::acc_t      data_out,
  input logic                  done_mat_mul
);

  import matmul_pkg::*;

  // all lanes at full scale, four products per sum
  localparam acc_t MAX_SUM = acc_t'(64'd4 * 64'd65535 * 64'd65535);

  int err_count = 0;

  // loaded operands, [row][column]
  lane_t model_a [`MM_SIZE][`MM_SIZE];
  lane_t model_b [`MM_SIZE][`MM_SIZE];

  acc_t  exp_c;
  lane_t exp_b;
  logic  a_identity;
  logic  all_max;

  task automatic log_mismatch(input string msg);
    err_count++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // C[row][col] as a plain sum of products, wrapping at 32 bits
  function automatic acc_t model_entry(input logic [`MM_SEL_W-1:0] sel);
    int   row;
    int   col;
    acc_t sum;
    row = sel / `MM_SIZE;
    col = sel % `MM_SIZE;
    sum = '0;
    for (int k = 0; k < `MM_SIZE; k++) begin
      sum = sum + acc_t'(model_a[row][k]) * acc_t'(model_b[k][col]);
    end
    return sum;
  endfunction

  // word k of A is column k, word k of B is row k
  always_ff @(posedge clk) begin
    if (enable_writing_to_mem) begin
      for (int n = 0; n < `MM_SIZE; n++) begin
        if (load.we_a) begin
          model_a[n][load.addr] <= load.data[n];
        end
        if (load.we_b) begin
          model_b[load.addr][n] <= load.data[n];
        end
      end
    end
  end

  // expected values for the select seen on this edge
  always_ff @(posedge clk) begin
    exp_c <= model_entry(out_sel);
    exp_b <= model_b[out_sel / `MM_SIZE][out_sel % `MM_SIZE];
  end

  always_comb begin
    a_identity = 1'b1;
    all_max    = 1'b1;
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        if (model_a[i][j] != ((i == j) ? lane_t'(1) : lane_t'(0))) begin
          a_identity = 1'b0;
        end
        if (model_a[i][j] != '1 || model_b[i][j] != '1) begin
          all_max = 1'b0;
        end
      end
    end
  end

  a_reset_idle : assert property (
    @(posedge clk) reset |=> !done_mat_mul && data_out == '0
  ) else log_mismatch("done or data_out not zero after reset");

  a_product : assert property (
    @(posedge clk) disable iff (reset)
    done_mat_mul |=> data_out == exp_c
  ) else log_mismatch($sformatf("data_out %h, model product %h",
                                $sampled(data_out), $sampled(exp_c)));

  a_identity_gives_b : assert property (
    @(posedge clk) disable iff (reset)
    done_mat_mul && a_identity |=> data_out == acc_t'(exp_b)
  ) else log_mismatch($sformatf("identity A, data_out %h, B entry %h",
                                $sampled(data_out), $sampled(exp_b)));

  a_full_scale_wraps : assert property (
    @(posedge clk) disable iff (reset)
    done_mat_mul && all_max |=> data_out == MAX_SUM
  ) else log_mismatch($sformatf("full scale, data_out %h, expected %h",
                                $sampled(data_out), MAX_SUM));

  a_done_latency : assert property (
    @(posedge clk) disable iff (reset)
    $rose(start_mat_mul) |-> !done_mat_mul [*`MM_DONE_COUNT+1] ##1 done_mat_mul
  ) else log_mismatch("done_mat_mul did not rise at the expected cycle");

  a_done_falls : assert property (
    @(posedge clk) disable iff (reset)
    !start_mat_mul |=> !done_mat_mul
  ) else log_mismatch("done_mat_mul still high a cycle after start dropped");

  a_done_rise_with_start : assert property (
    @(posedge clk) disable iff (reset)
    $rose(done_mat_mul) |-> start_mat_mul
  ) else log_mismatch("done_mat_mul rose while start_mat_mul was low");

endmodule

/* sim/tb_matmul_top.sv */
`include "matmul_params.svh"

module tb_matmul_top;

  import matmul_pkg::*;

  localparam logic [15:0] SEED         = 16'd60;
  localparam int          DONE_TIMEOUT = 4 * `MM_DONE_COUNT;
  localparam int          FALL_TIMEOUT = 8;

  logic                 clk = 1'b0;
  logic                 reset;
  load_req_t            load;
  logic                 enable_writing_to_mem;
  logic                 start_mat_mul;
  logic [`MM_SEL_W-1:0] out_sel;
  acc_t                 data_out;
  logic                 done_mat_mul;

  logic [15:0] lfsr;
  int          timeouts;

  // operands as [row][column]
  lane_t mat_a [`MM_SIZE][`MM_SIZE];
  lane_t mat_b [`MM_SIZE][`MM_SIZE];

  matmul_top UUT (
    .clk                   (clk),
    .reset                 (reset),
    .load                  (load),
    .enable_writing_to_mem (enable_writing_to_mem),
    .start_mat_mul         (start_mat_mul),
    .out_sel               (out_sel),
    .data_out              (data_out),
    .done_mat_mul          (done_mat_mul)
  );

  matmul_checks u_checks (
    .clk                   (clk),
    .reset                 (reset),
    .load                  (load),
    .enable_writing_to_mem (enable_writing_to_mem),
    .start_mat_mul         (start_mat_mul),
    .out_sel               (out_sel),
    .data_out              (data_out),
    .done_mat_mul          (done_mat_mul)
  );

  always #4 clk = ~clk;

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  task automatic random_lane(output lane_t value);
    value = '0;
    for (int n = 0; n < `MM_LANE_W; n++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[`MM_LANE_W-2:0], lfsr[0]};
    end
  endtask

  // inputs move just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic fill_random();
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        random_lane(mat_a[i][j]);
        random_lane(mat_b[i][j]);
      end
    end
  endtask

  task automatic fill_identity_a();
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        mat_a[i][j] = (i == j) ? lane_t'(1) : lane_t'(0);
        random_lane(mat_b[i][j]);
      end
    end
  endtask

  task automatic fill_full_scale();
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        mat_a[i][j] = '1;
        mat_b[i][j] = '1;
      end
    end
  endtask

  // one data field feeds both memories, so A and B words go on separate cycles
  task automatic load_operands();
    row_t word_a;
    row_t word_b;
    for (int k = 0; k < `MM_SIZE; k++) begin
      for (int n = 0; n < `MM_SIZE; n++) begin
        word_a[n] = mat_a[n][k];
        word_b[n] = mat_b[k][n];
      end
      enable_writing_to_mem = 1'b1;
      load.addr = k[`MM_ADDR_W-1:0];
      load.data = word_a;
      load.we_a = 1'b1;
      load.we_b = 1'b0;
      next_cycle();
      load.data = word_b;
      load.we_a = 1'b0;
      load.we_b = 1'b1;
      next_cycle();
    end
    enable_writing_to_mem = 1'b0;
    load = '0;
  endtask

  task automatic run_and_read(input string name);
    int cycles;
    $display("run: %s", name);
    start_mat_mul = 1'b1;
    next_cycle();
    cycles = 0;
    while (!done_mat_mul && cycles < DONE_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (!done_mat_mul) begin
      $display("timeout: done_mat_mul never rose during run %s", name);
      timeouts++;
    end
    // every select while done, the last one lands a cycle later
    for (int sel = 0; sel < `MM_SIZE * `MM_SIZE; sel++) begin
      out_sel = sel[`MM_SEL_W-1:0];
      next_cycle();
    end
    next_cycle();
    start_mat_mul = 1'b0;
    next_cycle();
    cycles = 0;
    while (done_mat_mul && cycles < FALL_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (done_mat_mul) begin
      $display("timeout: done_mat_mul stayed high after run %s", name);
      timeouts++;
    end
    next_cycle();
  endtask

  initial begin
    reset                 = 1'b1;
    load                  = '0;
    enable_writing_to_mem = 1'b0;
    start_mat_mul         = 1'b0;
    out_sel               = '0;
    lfsr                  = SEED;
    timeouts              = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (2) next_cycle();

    fill_random();
    load_operands();
    run_and_read("random operands");

    fill_identity_a();
    load_operands();
    run_and_read("identity A");

    fill_full_scale();
    load_operands();
    run_and_read("full scale lanes");

    // new operands right after a run, the tile must start from zero
    fill_random();
    load_operands();
    run_and_read("second random operands");

    repeat (2) next_cycle();
    $display("errors: checks %0d, timeouts %0d", u_checks.err_count, timeouts);
    if (u_checks.err_count == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/matmul_pkg.sv
design/operand_feeder.sv
design/processing_element.sv
design/systolic_array.sv
design/matmul_top.sv
sim/tb_matmul_checks.sv
sim/tb_matmul_top.sv

/* Bender.yml */
package:
  name: matmul

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/matmul_pkg.sv
      - design/operand_feeder.sv
      - design/processing_element.sv
      - design/systolic_array.sv
      - design/matmul_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_matmul_checks.sv
      - sim/tb_matmul_top.sv
